// ==== design/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// datapath width, used for both data words and byte addresses
`define DCACHE_WORD_W 32

// cache geometry, two ways of DCACHE_SETS rows
`define DCACHE_SETS   8
`define DCACHE_IDX_W  3   // log2 of DCACHE_SETS
`define DCACHE_TAG_W  26  // word width minus index, block offset and byte offset
`define DCACHE_WORDS  2   // words per block

// the flush ends by storing the hit count here
`define DCACHE_HITCOUNT_ADDR 32'h0000_3100

`endif

// ==== design/cpu_types_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package cpu_types_pkg;

  typedef logic [`DCACHE_WORD_W-1:0] word_t;

  // byte address as the cache sees it
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0] tag;
    logic [`DCACHE_IDX_W-1:0] idx;     // set select
    logic                     blkoff;  // word within the block
    logic [1:0]               byteoff; // ignored, word accesses only
  } dcache_addr_t;

  // processor side request, held until hit
  typedef struct packed {
    logic         ren;
    logic         wen;
    dcache_addr_t addr;
    word_t        store;
    logic         halt;  // level, stays up until reset
  } cpu_req_t;

  typedef struct packed {
    logic  hit;
    word_t load;
    logic  flushed;  // held once the flush and hit count store are done
  } cpu_resp_t;

endpackage

`default_nettype wire

// ==== design/dcache_pkg.sv ====
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

  // one row of one way
  typedef struct packed {
    logic [`DCACHE_TAG_W-1:0]                        tag;
    cpu_types_pkg::word_t [`DCACHE_WORDS-1:0]        data;
    logic                                            valid;
    logic                                            dirty;
  } cache_row_t;

  typedef logic way_sel_t;  // 0 = way 0, 1 = way 1

  typedef enum logic [3:0] {
    IDLE, FETCH1, FETCH2, WB1, WB2,
    FLUSH1, FLUSH2, FLUSH3, FLUSH4,
    STORE_COUNT, FLUSHED
  } dcache_state_t;

  // memory side, plain request levels
  typedef struct packed {
    logic                 ren;
    logic                 wen;
    cpu_types_pkg::word_t addr;
    cpu_types_pkg::word_t store;
  } mem_req_t;

  typedef struct packed {
    logic                 dwait;  // high while the transfer is not done
    cpu_types_pkg::word_t load;
  } mem_resp_t;

  // single row update, one data word plus tag and state bits
  typedef struct packed {
    logic                     en;
    way_sel_t                 way;
    logic [`DCACHE_IDX_W-1:0] idx;
    logic                     word_sel;
    logic [`DCACHE_TAG_W-1:0] tag;
    cpu_types_pkg::word_t     data;
    logic                     valid;
    logic                     dirty;
  } row_write_t;

endpackage

`default_nettype wire

// ==== design/dcache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_array (
  input  logic                          CLK,
  input  logic                          nRST,
  input  cpu_types_pkg::dcache_addr_t   lookup_addr,
  input  logic                          lookup_en,   // request read or write
  input  logic [`DCACHE_IDX_W-1:0]      flush_idx,
  input  dcache_pkg::row_write_t        row_write,
  output logic                          hit,
  output dcache_pkg::way_sel_t          hit_way,
  output dcache_pkg::way_sel_t          victim_way,
  output cpu_types_pkg::word_t          hit_word,
  output dcache_pkg::cache_row_t        victim_row,
  output dcache_pkg::cache_row_t [1:0]  flush_rows
);

  // tag and block storage for both ways
  logic [`DCACHE_TAG_W-1:0]                 tags   [2][`DCACHE_SETS];
  cpu_types_pkg::word_t [`DCACHE_WORDS-1:0] blocks [2][`DCACHE_SETS];

  // per row state bits, cleared by reset
  logic [1:0][`DCACHE_SETS-1:0] valid;
  logic [1:0][`DCACHE_SETS-1:0] dirty;
  logic [`DCACHE_SETS-1:0]      lru;  // points at the way to evict next

  dcache_pkg::cache_row_t [1:0] set_rows;  // both ways of the looked-up set
  logic [1:0]                   way_hit;

  // gather rows of the request set and of the flush set
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      set_rows[w].tag   = tags[w][lookup_addr.idx];
      set_rows[w].data  = blocks[w][lookup_addr.idx];
      set_rows[w].valid = valid[w][lookup_addr.idx];
      set_rows[w].dirty = dirty[w][lookup_addr.idx];

      flush_rows[w].tag   = tags[w][flush_idx];
      flush_rows[w].data  = blocks[w][flush_idx];
      flush_rows[w].valid = valid[w][flush_idx];
      flush_rows[w].dirty = dirty[w][flush_idx];
    end
  end

  // tag compare in both ways
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_hit[w] = lookup_en && set_rows[w].valid && (set_rows[w].tag == lookup_addr.tag);
    end
  end

  assign hit        = |way_hit;
  assign hit_way    = way_hit[1];   // only one way can match a tag
  assign hit_word   = set_rows[hit_way].data[lookup_addr.blkoff];
  assign victim_way = lru[lookup_addr.idx];
  assign victim_row = set_rows[victim_way];

  // payload side of a row write
  always_ff @(posedge CLK) begin
    if (row_write.en) begin
      tags[row_write.way][row_write.idx]                       <= row_write.tag;
      blocks[row_write.way][row_write.idx][row_write.word_sel] <= row_write.data;
    end
  end

  // valid, dirty and lru
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
      lru   <= '0;
    end else begin
      if (row_write.en) begin
        valid[row_write.way][row_write.idx] <= row_write.valid;
        dirty[row_write.way][row_write.idx] <= row_write.dirty;
      end
      // any hit makes the other way the next victim
      if (hit) begin
        lru[lookup_addr.idx] <= ~hit_way;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dcache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_controller (
  input  logic                          CLK,
  input  logic                          nRST,
  input  cpu_types_pkg::cpu_req_t       cpu_req,
  input  logic                          hit,
  input  dcache_pkg::way_sel_t          hit_way,
  input  dcache_pkg::way_sel_t          victim_way,
  input  dcache_pkg::cache_row_t        victim_row,
  input  dcache_pkg::cache_row_t [1:0]  flush_rows,
  input  dcache_pkg::mem_resp_t         mem_resp,
  output dcache_pkg::mem_req_t          mem_req,
  output dcache_pkg::row_write_t        row_write,
  output logic [`DCACHE_IDX_W-1:0]      flush_idx,
  output logic                          flushed
);

  dcache_pkg::dcache_state_t state, next_state;

  cpu_types_pkg::word_t   hit_count;
  logic                   after_fill;  // last cycle was FETCH2
  logic                   mem_done;    // word transfer completes this edge
  logic                   access;
  logic                   flush_way;
  logic                   flush_word;
  dcache_pkg::cache_row_t flush_row;

  // rebuild a byte address from tag, set and word
  function automatic cpu_types_pkg::word_t block_addr(
    input logic [`DCACHE_TAG_W-1:0] tag,
    input logic [`DCACHE_IDX_W-1:0] idx,
    input logic                     word
  );
    cpu_types_pkg::dcache_addr_t a;
    a.tag     = tag;
    a.idx     = idx;
    a.blkoff  = word;
    a.byteoff = 2'b00;
    return a;
  endfunction

  assign mem_done = !mem_resp.dwait;
  assign access   = cpu_req.ren | cpu_req.wen;

  // FLUSH1..4 walk way 0 word 0, way 0 word 1, way 1 word 0, way 1 word 1
  assign flush_way  = (state == dcache_pkg::FLUSH3) || (state == dcache_pkg::FLUSH4);
  assign flush_word = (state == dcache_pkg::FLUSH2) || (state == dcache_pkg::FLUSH4);
  assign flush_row  = flush_rows[flush_way];

  always_comb begin
    next_state = state;  // wait high holds the state
    case (state)
      dcache_pkg::IDLE: begin
        if (cpu_req.halt) begin
          next_state = dcache_pkg::FLUSH1;
        end else if (access && !hit) begin
          // dirty victim goes out first
          next_state = (victim_row.valid && victim_row.dirty) ? dcache_pkg::WB1
                                                              : dcache_pkg::FETCH1;
        end
      end
      dcache_pkg::FETCH1: if (mem_done) next_state = dcache_pkg::FETCH2;
      dcache_pkg::FETCH2: if (mem_done) next_state = dcache_pkg::IDLE;
      dcache_pkg::WB1:    if (mem_done) next_state = dcache_pkg::WB2;
      dcache_pkg::WB2:    if (mem_done) next_state = dcache_pkg::FETCH1;
      dcache_pkg::FLUSH1: if (mem_done) next_state = dcache_pkg::FLUSH2;
      dcache_pkg::FLUSH2: if (mem_done) next_state = dcache_pkg::FLUSH3;
      dcache_pkg::FLUSH3: if (mem_done) next_state = dcache_pkg::FLUSH4;
      dcache_pkg::FLUSH4: begin
        if (mem_done) begin
          next_state = (flush_idx == `DCACHE_IDX_W'(`DCACHE_SETS - 1)) ?
                       dcache_pkg::STORE_COUNT : dcache_pkg::FLUSH1;
        end
      end
      dcache_pkg::STORE_COUNT: if (mem_done) next_state = dcache_pkg::FLUSHED;
      dcache_pkg::FLUSHED:     next_state = dcache_pkg::FLUSHED;  // until reset
      default:                 next_state = dcache_pkg::IDLE;
    endcase
  end

  always_comb begin
    mem_req            = '0;
    row_write          = '0;
    row_write.idx      = cpu_req.addr.idx;
    row_write.tag      = cpu_req.addr.tag;
    flushed            = (state == dcache_pkg::FLUSHED);
    case (state)
      dcache_pkg::IDLE: begin
        // write hit lands in the matching way, marks it dirty
        row_write.en       = hit && cpu_req.wen;
        row_write.way      = hit_way;
        row_write.word_sel = cpu_req.addr.blkoff;
        row_write.data     = cpu_req.store;
        row_write.valid    = 1'b1;
        row_write.dirty    = 1'b1;
      end
      dcache_pkg::FETCH1, dcache_pkg::FETCH2: begin
        mem_req.ren        = 1'b1;
        mem_req.addr       = block_addr(cpu_req.addr.tag, cpu_req.addr.idx,
                                        state == dcache_pkg::FETCH2);
        row_write.en       = mem_done;
        row_write.way      = victim_way;
        row_write.word_sel = (state == dcache_pkg::FETCH2);
        row_write.data     = mem_resp.load;
        row_write.valid    = (state == dcache_pkg::FETCH2);  // valid once both words in
        row_write.dirty    = 1'b0;
      end
      dcache_pkg::WB1, dcache_pkg::WB2: begin
        mem_req.wen   = 1'b1;
        mem_req.addr  = block_addr(victim_row.tag, cpu_req.addr.idx, state == dcache_pkg::WB2);
        mem_req.store = victim_row.data[state == dcache_pkg::WB2];
      end
      dcache_pkg::FLUSH1, dcache_pkg::FLUSH2, dcache_pkg::FLUSH3, dcache_pkg::FLUSH4: begin
        mem_req.wen   = flush_row.dirty;  // clean rows pass straight through
        mem_req.addr  = block_addr(flush_row.tag, flush_idx, flush_word);
        mem_req.store = flush_row.data[flush_word];
      end
      dcache_pkg::STORE_COUNT: begin
        mem_req.wen   = 1'b1;
        mem_req.addr  = `DCACHE_HITCOUNT_ADDR;
        mem_req.store = hit_count;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state      <= dcache_pkg::IDLE;
      flush_idx  <= '0;
      hit_count  <= '0;
      after_fill <= 1'b0;
    end else begin
      state      <= next_state;
      after_fill <= (state == dcache_pkg::FETCH2);
      if (state == dcache_pkg::FLUSH4 && mem_done) begin
        flush_idx <= flush_idx + 1'b1;  // next set
      end
      // the hit that ends a refill is not counted
      if (state == dcache_pkg::IDLE && hit && !after_fill) begin
        hit_count <= hit_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache (
  input  logic                     CLK,
  input  logic                     nRST,
  input  cpu_types_pkg::cpu_req_t  cpu_req,
  output cpu_types_pkg::cpu_resp_t cpu_resp,
  output dcache_pkg::mem_req_t     mem_req,
  input  dcache_pkg::mem_resp_t    mem_resp
);

  logic                         hit;
  dcache_pkg::way_sel_t         hit_way;
  dcache_pkg::way_sel_t         victim_way;
  cpu_types_pkg::word_t         hit_word;
  dcache_pkg::cache_row_t       victim_row;
  dcache_pkg::cache_row_t [1:0] flush_rows;
  dcache_pkg::row_write_t       row_write;
  logic [`DCACHE_IDX_W-1:0]     flush_idx;
  logic                         flushed;

  // processor response straight from array and controller
  assign cpu_resp.hit     = hit;
  assign cpu_resp.load    = hit_word;
  assign cpu_resp.flushed = flushed;

  dcache_tag_array array_inst (
    .CLK         (CLK),
    .nRST        (nRST),
    .lookup_addr (cpu_req.addr),
    .lookup_en   (cpu_req.ren | cpu_req.wen),
    .flush_idx   (flush_idx),
    .row_write   (row_write),
    .hit         (hit),
    .hit_way     (hit_way),
    .victim_way  (victim_way),
    .hit_word    (hit_word),
    .victim_row  (victim_row),
    .flush_rows  (flush_rows)
  );

  dcache_controller ctrl_inst (
    .CLK        (CLK),
    .nRST       (nRST),
    .cpu_req    (cpu_req),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way),
    .victim_row (victim_row),
    .flush_rows (flush_rows),
    .mem_resp   (mem_resp),
    .mem_req    (mem_req),
    .row_write  (row_write),
    .flush_idx  (flush_idx),
    .flushed    (flushed)
  );

endmodule

`default_nettype wire

// ==== tests/dcache_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
  input  logic                  CLK,
  input  logic                  nRST,
  input  dcache_pkg::mem_req_t  mem_req,
  output dcache_pkg::mem_resp_t mem_resp,
  input  logic [2:0]            latency  // wait cycles per word transfer
);

  cpu_types_pkg::word_t mem [4096];  // word addressed, byte address bits 13:2
  logic [2:0]           wait_cnt;
  logic                 active;

  // fill pattern over the whole word index
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = 32'hA5C3_0000 ^ (32'(i) << 18) ^ (32'(i) << 2);
    end
  end

  assign active         = mem_req.ren | mem_req.wen;
  assign mem_resp.dwait = active && (wait_cnt < latency);  // low when idle
  assign mem_resp.load  = mem[mem_req.addr[13:2]];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (active && mem_resp.dwait) begin
      wait_cnt <= wait_cnt + 3'd1;
    end else begin
      wait_cnt <= '0;  // transfer done or no request
    end
  end

  always @(posedge CLK) begin
    if (mem_req.wen && !mem_resp.dwait) begin
      mem[mem_req.addr[13:2]] <= mem_req.store;
    end
  end

endmodule

`default_nettype wire

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;

  logic                     CLK;
  logic                     nRST;
  cpu_types_pkg::cpu_req_t  cpu_req;
  cpu_types_pkg::cpu_resp_t cpu_resp;
  dcache_pkg::mem_req_t     mem_req;
  dcache_pkg::mem_resp_t    mem_resp;
  logic [2:0]               latency;

  logic [31:0] rng_state;
  int          error_count;
  int          tests_run;
  int          tests_failed;
  int          errs_at_start;
  int          hits_expected;  // hits with no refill in front of them
  logic        stress;         // random latency per access
  cpu_types_pkg::word_t wr_addr [$];
  cpu_types_pkg::word_t wr_data [$];

  dcache dcache_inst (.CLK(CLK), .nRST(nRST), .cpu_req(cpu_req), .cpu_resp(cpu_resp),
                      .mem_req(mem_req), .mem_resp(mem_resp));

  dcache_mem_model mem_inst (.CLK(CLK), .nRST(nRST), .mem_req(mem_req),
                             .mem_resp(mem_resp), .latency(latency));

  always #10 CLK = ~CLK;

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // tag at bit 6, set at bit 3, word at bit 2
  function automatic cpu_types_pkg::word_t make_addr(int tag, int idx, int blk);
    return cpu_types_pkg::word_t'((tag << 6) | (idx << 3) | (blk << 2));
  endfunction

  function automatic cpu_types_pkg::word_t init_word(cpu_types_pkg::word_t addr);
    return 32'hA5C3_0000 ^ ({20'd0, addr[13:2]} << 18) ^ ({20'd0, addr[13:2]} << 2);
  endfunction

  task automatic compare_word(string name, cpu_types_pkg::word_t got,
                              cpu_types_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%08h expected 0x%08h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_resp(string name, cpu_types_pkg::cpu_resp_t got,
                              cpu_types_pkg::cpu_resp_t exp);
    if (got !== exp) begin
      $display("** Error: %s got 0x%09h expected 0x%09h", name, got, exp);
      error_count++;
    end
  endtask

  // memory model content against the expected store word
  task automatic compare_mem(string name, cpu_types_pkg::word_t addr,
                             cpu_types_pkg::word_t exp);
    compare_word($sformatf("%s mem[0x%04h]", name, addr), mem_inst.mem[addr[13:2]], exp);
  endtask

  // hold a request until hit, return the load and the cycles it took
  task automatic access(logic wr, cpu_types_pkg::word_t addr, cpu_types_pkg::word_t data,
                        output cpu_types_pkg::cpu_resp_t resp, output int cycles);
    @(negedge CLK);
    latency       = stress ? 3'(xorshift() % 5) : 3'd1;
    cpu_req.ren   = !wr;
    cpu_req.wen   = wr;
    cpu_req.addr  = addr;
    cpu_req.store = data;
    cycles = 0;
    resp   = '0;
    while (cycles < 200) begin
      @(posedge CLK);
      cycles++;
      if (cpu_resp.hit) begin
        resp = cpu_resp;
        break;
      end
    end
    if (!resp.hit) begin
      $display("timeout: no hit for access to 0x%08h", addr);
      error_count++;
    end
    if (cycles == 1) hits_expected++;
    if (wr) begin
      wr_addr.push_back(addr);
      wr_data.push_back(data);
    end
    @(negedge CLK);
    cpu_req.ren = 1'b0;
    cpu_req.wen = 1'b0;
  endtask

  task automatic read_check(string name, cpu_types_pkg::word_t addr,
                            cpu_types_pkg::word_t exp, output int cycles);
    cpu_types_pkg::cpu_resp_t resp;
    access(1'b0, addr, '0, resp, cycles);
    compare_resp(name, resp, {1'b1, exp, 1'b0});
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (error_count != errs_at_start) tests_failed++;
    $display("test %0d %s: %s", tests_run, name,
             (error_count == errs_at_start) ? "ok" : "failed");
    errs_at_start = error_count;
  endtask

  task automatic read_miss_hit(int idx);
    int cyc;
    read_check("miss load", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)), cyc);
    read_check("hit load", make_addr(1, idx, 1), init_word(make_addr(1, idx, 1)), cyc);
    if (cyc != 1) begin
      $display("second word of a filled block did not hit at once (%0d cycles)", cyc);
      error_count++;
    end
    finish_test("read miss then hit");
  endtask

  task automatic write_hit(int idx);
    int cyc;
    cpu_types_pkg::cpu_resp_t resp;
    cpu_types_pkg::word_t d;
    d = xorshift();
    read_check("fill load", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)), cyc);
    access(1'b1, make_addr(1, idx, 0), d, resp, cyc);
    read_check("written load", make_addr(1, idx, 0), d, cyc);
    compare_mem("untouched", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)));
    finish_test("write hit");
  endtask

  task automatic evict_dirty(int idx);
    int cyc;
    cpu_types_pkg::cpu_resp_t resp;
    cpu_types_pkg::word_t d;
    d = xorshift();
    read_check("tag1 fill", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)), cyc);
    access(1'b1, make_addr(1, idx, 0), d, resp, cyc);        // dirty way 0
    read_check("tag2 fill", make_addr(2, idx, 1), init_word(make_addr(2, idx, 1)), cyc);
    // the write hit left way 1 as victim, so tag1 is still only in the cache
    compare_mem("not evicted", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)));
    read_check("tag3 fill", make_addr(3, idx, 0), init_word(make_addr(3, idx, 0)), cyc);
    compare_mem("written back", make_addr(1, idx, 0), d);
    compare_mem("written back", make_addr(1, idx, 1), init_word(make_addr(1, idx, 1)));
    read_check("tag1 reload", make_addr(1, idx, 0), d, cyc);
    finish_test("eviction with write-back");
  endtask

  task automatic lru_choice(int idx);
    int cyc;
    read_check("A fill", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)), cyc);
    read_check("B fill", make_addr(2, idx, 0), init_word(make_addr(2, idx, 0)), cyc);
    read_check("A touch", make_addr(1, idx, 1), init_word(make_addr(1, idx, 1)), cyc);
    read_check("C fill", make_addr(3, idx, 0), init_word(make_addr(3, idx, 0)), cyc);
    read_check("A kept", make_addr(1, idx, 0), init_word(make_addr(1, idx, 0)), cyc);
    if (cyc != 1) begin
      $display("touched block was evicted instead of the untouched one");
      error_count++;
    end
    finish_test("LRU choice");
  endtask

  task automatic flush_all();
    int cyc;
    @(negedge CLK);
    latency      = 3'd1;
    cpu_req.halt = 1'b1;
    cyc = 0;
    while (!cpu_resp.flushed && cyc < 2000) begin
      @(posedge CLK);
      cyc++;
    end
    if (!cpu_resp.flushed) begin
      $display("timeout: flushed never rose after halt");
      error_count++;
    end
    foreach (wr_addr[i]) compare_mem("flushed", wr_addr[i], wr_data[i]);
    compare_mem("hit count", `DCACHE_HITCOUNT_ADDR, cpu_types_pkg::word_t'(hits_expected));
    finish_test("flush");
  endtask

  initial begin
    CLK           = 1'b0;
    nRST          = 1'b0;
    cpu_req       = '0;
    cpu_req.ren   = 1'b1;  // read waits through reset, no row may answer it
    cpu_req.addr  = make_addr(1, 0, 0);
    latency       = 3'd1;
    rng_state     = 32'd52198;
    error_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    errs_at_start = 0;
    hits_expected = 0;
    stress        = 1'b0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    compare_word("mem_req.ren", {31'd0, mem_req.ren}, '0);
    compare_word("mem_req.wen", {31'd0, mem_req.wen}, '0);
    compare_word("cpu_resp.hit", {31'd0, cpu_resp.hit}, '0);
    compare_word("cpu_resp.flushed", {31'd0, cpu_resp.flushed}, '0);
    cpu_req = '0;
    read_miss_hit(0);
    write_hit(1);
    evict_dirty(2);
    lru_choice(3);
    stress = 1'b1;  // same checks under random wait
    read_miss_hit(4);
    write_hit(5);
    evict_dirty(6);
    stress = 1'b0;
    flush_all();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/cpu_types_pkg.sv
design/dcache_pkg.sv
design/dcache_tag_array.sv
design/dcache_controller.sv
design/dcache.sv
tests/dcache_mem_model.sv
tests/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "PASS: all tests"

clean:
	rm -rf $(OBJDIR)
